// File: Bender.yml
package:
  name: dualIssue

sources:
  - hdl/dualIssuePkg.sv
  - hdl/instDecode.sv
  - hdl/issueCheck.sv
  - hdl/idExReg.sv
  - hdl/execUnit.sv
  - hdl/dualIssueTop.sv
  - target: simulation
    files:
      - bench/clockGen.sv
      - bench/dualIssueTb.sv

// File: bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/dualIssueTb.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueTb import dualIssuePkg::*; ();

    localparam int testCycles = 3 * (11 + 5 + 8 + 3) + 7 + 3; // three edges per pair.
    localparam logic [47:0] fnList = {fnSrl, fnSll, fnSlt, fnXor, fnOr, fnAnd, fnSubu, fnAddu};

    logic       clk;
    logic       rstN;
    logic       stall;
    logic       flush;
    fetchPair   fetch;
    operandPair masterOperands;
    operandPair slaveOperands;
    logic       slaveTaken;
    exResult    masterResult;
    exResult    slaveResult;

    logic [31:0] seed = 32'haf274332;
    logic [31:0] pc = 32'h0040_0000;
    int          errors = 0;
    int          checks = 0;

    clockGen clockGen_inst (.clk (clk), .rstN (rstN));

    dualIssueTop dualIssueTop_inst (
        .clk (clk), .rstN (rstN), .stall (stall), .flush (flush), .fetch (fetch),
        .masterOperands (masterOperands), .slaveOperands (slaveOperands),
        .slaveTaken (slaveTaken), .masterResult (masterResult), .slaveResult (slaveResult)
    );

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] nextRand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic operandPair rndOps();
        return '{nextRand(), nextRand()};
    endfunction

    // k 0..7 selects an R-type function, 8..10 ADDIU, ORI, LUI.
    function automatic logic [31:0] aluInst(input int k, input logic [4:0] rd,
            input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        if (k < 8) return {opSpecial, rs, rt, rd, imm[4:0], fnList[k * 6 +: 6]};
        return {(k == 8) ? opAddiu : ((k == 9) ? opOri : opLui), rs, rd, imm};
    endfunction

    // expected lane result plus a mask of the fields the rules define.
    function automatic exResult model(input logic [31:0] inst, input logic [31:0] pcIn,
                                      input operandPair ops, input logic v,
                                      output exResult mask);
        exResult     r;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] sImm;
        rs   = ops.rsValue;
        rt   = ops.rtValue;
        sImm = {{16{inst[15]}}, inst[15:0]};
        r    = '0;
        mask = '0;
        {mask.valid, mask.regWen, mask.memEn, mask.memWrite, mask.branchTaken,
         mask.reservedInst} = '1;
        r.valid        = v;
        r.regWen       = v;
        r.regWaddr     = inst[20:16];
        r.storeData    = rt;
        r.branchTarget = pcIn + 32'd4 + (sImm << 2);
        case (inst[31:26])
            opSpecial: begin
                r.regWaddr = inst[15:11];
                case (inst[5:0])
                    fnAddu:  r.result = rs + rt;
                    fnSubu:  r.result = rs - rt;
                    fnAnd:   r.result = rs & rt;
                    fnOr:    r.result = rs | rt;
                    fnXor:   r.result = rs ^ rt;
                    fnSlt:   r.result = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                    fnSll:   r.result = rt << inst[10:6];
                    fnSrl:   r.result = rt >> inst[10:6];
                    default: r.reservedInst = v;
                endcase
            end
            opAddiu: r.result = rs + sImm;
            opOri:   r.result = rs | {16'h0000, inst[15:0]}; // zero extended.
            opLui:   r.result = {inst[15:0], 16'h0000};
            opLw, opSw: begin
                r.result       = rs + sImm; // address.
                r.memEn        = v;
                r.memWrite     = v && (inst[31:26] == opSw);
                r.regWen       = v && (inst[31:26] == opLw);
                mask.storeData = {32{r.memWrite}};
            end
            opBeq: begin
                r.regWen          = 1'b0;
                r.branchTaken     = v && (rs == rt);
                mask.branchTarget = {32{v}};
            end
            default: r.reservedInst = v;
        endcase
        r.regWen      = r.regWen && !r.reservedInst;
        mask.result   = {32{r.regWen || r.memEn}};
        mask.regWaddr = {5{r.regWen}};
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [159:0] exp,
                              input logic [159:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    task automatic checkRes(input string name, input exResult act, input logic [31:0] inst,
                            input logic [31:0] pcIn, input operandPair ops, input logic v);
        exResult exp;
        exResult mask;
        exp = model(inst, pcIn, ops, v, mask);
        checkValue(name, exp & mask, act & mask);
    endtask

    // one pair through decode and execute, results two edges after capture.
    task automatic runPair(input logic [31:0] mInst, input logic [31:0] sInst,
                           input logic sValid, input logic expTaken, input logic eqOps);
        operandPair mOps;
        operandPair sOps;
        mOps = rndOps();
        sOps = rndOps();
        if (eqOps) mOps.rtValue = mOps.rsValue;
        @(posedge clk);
        fetch          <= '{1'b1, pc, mInst, sValid, pc + 32'd4, sInst};
        masterOperands <= mOps;
        slaveOperands  <= sOps;
        @(negedge clk);
        checkValue("slaveTaken", expTaken, slaveTaken);
        @(posedge clk);
        fetch <= '0;
        @(posedge clk);
        @(negedge clk);
        checkRes("masterResult", masterResult, mInst, pc, mOps, 1'b1);
        checkRes("slaveResult", slaveResult, sInst, pc + 32'd4, sOps, sValid && expTaken);
        pc = pc + 32'd8;
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic aluPairTest();
        logic [31:0] r;
        for (int i = 0; i < 11; i++) begin
            r = nextRand();
            // master writes r16..r31, slave reads r0..r15 only.
            runPair(aluInst(i, {1'b1, r[3:0]}, r[8:4], r[13:9], {i >= 8, r[30:16]}),
                    aluInst((i + 5) % 11, r[18:14], {1'b0, r[22:19]}, {1'b0, r[26:23]},
                            r[15:0]),
                    1'b1, 1'b1, 1'b0);
        end
    endtask

    task automatic hazardTest();
        runPair(aluInst(0, 5'd7, 5'd1, 5'd2, 16'h0), aluInst(1, 5'd3, 5'd7, 5'd2, 16'h0),
                1'b1, 1'b0, 1'b0); // rs hazard.
        runPair(aluInst(1, 5'd3, 5'd7, 5'd2, 16'h0), 32'h0, 1'b0, 1'b0, 1'b0);
        runPair(aluInst(9, 5'd7, 5'd1, 5'd2, 16'h1234), aluInst(6, 5'd4, 5'd0, 5'd7, 16'h3),
                1'b1, 1'b0, 1'b0); // rt hazard.
        runPair(aluInst(6, 5'd4, 5'd0, 5'd7, 16'h3), 32'h0, 1'b0, 1'b0, 1'b0);
        runPair(aluInst(2, 5'd0, 5'd1, 5'd2, 16'h0), aluInst(3, 5'd5, 5'd0, 5'd0, 16'h0),
                1'b1, 1'b1, 1'b0); // r0 never blocks.
    endtask

    task automatic memBranchTest();
        logic [31:0] r;
        logic [31:0] inst;
        for (int k = 0; k < 4; k++) begin
            r    = nextRand();
            inst = {(k == 0) ? opLw : ((k == 1) ? opSw : opBeq), 5'd4, 5'd5, r[15:0]};
            runPair(aluInst(0, 5'd20, 5'd1, 5'd1, 16'h0), inst, 1'b1, 1'b0, 1'b0);
            // a branch master keeps the slave out.
            runPair(inst, aluInst(0, 5'd2, 5'd1, 5'd1, 16'h0), 1'b1, k < 2, k == 3);
        end
    endtask

    task automatic stallFlushTest();
        logic [31:0] aInst;
        logic [31:0] bInst;
        operandPair  aOps;
        operandPair  bOps;
        exResult     held;
        aInst = aluInst(8, 5'd9, 5'd1, 5'd0, 16'h8001);
        bInst = aluInst(3, 5'd10, 5'd2, 5'd3, 16'h0);
        aOps  = rndOps();
        bOps  = rndOps();
        @(posedge clk);
        fetch          <= '{1'b1, pc, aInst, 1'b0, 32'h0, 32'h0};
        masterOperands <= aOps;
        @(posedge clk); // A now in the lane register.
        fetch          <= '{1'b1, pc + 32'd8, bInst, 1'b1, pc + 32'd12, aInst};
        masterOperands <= bOps;
        stall          <= 1'b1;
        @(negedge clk);
        held = masterResult;
        checkValue("slaveTaken", 1'b0, slaveTaken);
        @(posedge clk);
        @(negedge clk);
        checkValue("slaveTaken", 1'b0, slaveTaken);
        checkValue("masterResult", held, masterResult);
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        checkValue("masterResult", held, masterResult);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        checkRes("masterResult", masterResult, aInst, pc, aOps, 1'b1);
        checkValue("slaveTaken", 1'b0, slaveTaken);
        @(posedge clk);
        flush <= 1'b0;
        fetch <= '0;
        @(negedge clk);
        checkRes("masterResult", masterResult, bInst, pc + 32'd8, bOps, 1'b1);
        @(posedge clk);
        @(negedge clk);
        checkRes("masterResult", masterResult, bInst, pc + 32'd8, bOps, 1'b0);
        checkValue("slaveResult.valid", 1'b0, slaveResult.valid);
        pc = pc + 32'd16;
    endtask

    task automatic reservedTest();
        logic [31:0] r;
        r = nextRand();
        runPair({6'h3f, r[25:0]}, 32'h0, 1'b0, 1'b0, 1'b0);
        runPair({opSpecial, r[25:6], 6'h3f}, 32'h0, 1'b0, 1'b0, 1'b0);
        runPair(aluInst(0, 5'd0, 5'd1, 5'd1, 16'h0), {6'h3f, r[25:0]}, 1'b1, 1'b0, 1'b0);
    endtask

    // --------------------------------------------------
    // sequence and watchdog
    // --------------------------------------------------
    initial begin
        stall          = 1'b0;
        flush          = 1'b0;
        fetch          = '0;
        masterOperands = '0;
        slaveOperands  = '0;
        wait (rstN === 1'b1);
        @(negedge clk);
        checkRes("masterResult", masterResult, 32'h0, pc, '0, 1'b0);
        checkRes("slaveResult", slaveResult, 32'h0, pc, '0, 1'b0);
        aluPairTest();
        hazardTest();
        memBranchTest();
        stallFlushTest();
        reservedTest();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((testCycles + 50) * 100);
        $display("timeout, the tests did not finish within %0d cycles", testCycles + 50);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: dualIssueTop.f
hdl/dualIssuePkg.sv
hdl/instDecode.sv
hdl/issueCheck.sv
hdl/idExReg.sv
hdl/execUnit.sv
hdl/dualIssueTop.sv
bench/clockGen.sv
bench/dualIssueTb.sv

// File: hdl/dualIssuePkg.sv
`default_nettype none

package dualIssuePkg;

    // --------------------------------------------------
    // opcode and function field encodings
    // --------------------------------------------------
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    localparam logic [5:0] fnSll     = 6'h00;
    localparam logic [5:0] fnSrl     = 6'h02;
    localparam logic [5:0] fnAddu    = 6'h21;
    localparam logic [5:0] fnSubu    = 6'h23;
    localparam logic [5:0] fnAnd     = 6'h24;
    localparam logic [5:0] fnOr      = 6'h25;
    localparam logic [5:0] fnXor     = 6'h26;
    localparam logic [5:0] fnSlt     = 6'h2a;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluLui
    } aluOpE;

    // --------------------------------------------------
    // stage payloads
    // --------------------------------------------------
    typedef struct packed {
        logic        masterValid;
        logic [31:0] masterPc;
        logic [31:0] masterInst;
        logic        slaveValid;
        logic [31:0] slavePc;
        logic [31:0] slaveInst;
    } fetchPair;

    typedef struct packed {
        logic [31:0] rsValue;
        logic [31:0] rtValue;
    } operandPair;

    typedef struct packed {
        logic        valid;
        logic        regWen;
        logic [4:0]  regWaddr;
        aluOpE       aluOp;
        logic        aluSelB;      // immediate replaces rt.
        logic [4:0]  shamt;
        logic        memEn;
        logic        memWrite;
        logic        isBranch;
        logic        reservedInst;
        logic [4:0]  rsAddr;
        logic [4:0]  rtAddr;
        logic        usesRt;
        logic [31:0] pc;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
        logic [31:0] immValue;
    } decodedOp;

    typedef struct packed {
        logic        valid;
        logic        regWen;
        logic [4:0]  regWaddr;
        logic [31:0] result;
        logic        memEn;
        logic        memWrite;
        logic [31:0] storeData;
        logic        branchTaken;
        logic [31:0] branchTarget;
        logic        reservedInst;
    } exResult;

endpackage

`default_nettype wire

// File: hdl/dualIssueTop.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueTop import dualIssuePkg::*; (
    input  wire  clk,
    input  wire  rstN,
    input  wire  stall,
    input  wire  flush,
    input  wire fetchPair   fetch,
    input  wire operandPair masterOperands,
    input  wire operandPair slaveOperands,
    output logic    slaveTaken,
    output exResult masterResult,
    output exResult slaveResult
);

    decodedOp masterDec;
    decodedOp slaveDec;
    decodedOp masterEx;
    decodedOp slaveEx;

    logic masterLoad;
    logic masterClear;
    logic slaveLoad;
    logic slaveClear;
    logic execLoad;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    instDecode masterDecode (
        .inst      (fetch.masterInst),
        .pc        (fetch.masterPc),
        .instValid (fetch.masterValid),
        .operands  (masterOperands),
        .op        (masterDec)
    );

    instDecode slaveDecode (
        .inst      (fetch.slaveInst),
        .pc        (fetch.slavePc),
        .instValid (fetch.slaveValid),
        .operands  (slaveOperands),
        .op        (slaveDec)
    );

    issueCheck issueCheck_inst (
        .masterOp    (masterDec),
        .slaveOp     (slaveDec),
        .stall       (stall),
        .flush       (flush),
        .slaveTaken  (slaveTaken),
        .masterLoad  (masterLoad),
        .masterClear (masterClear),
        .slaveLoad   (slaveLoad),
        .slaveClear  (slaveClear),
        .execLoad    (execLoad)
    );

    // --------------------------------------------------
    // decode/execute register and execute
    // --------------------------------------------------
    idExReg masterIdEx (
        .clk (clk), .rstN (rstN), .clear (masterClear), .load (masterLoad),
        .dIn (masterDec), .dOut (masterEx)
    );

    idExReg slaveIdEx (
        .clk (clk), .rstN (rstN), .clear (slaveClear), .load (slaveLoad),
        .dIn (slaveDec), .dOut (slaveEx)
    );

    execUnit masterExec (
        .clk (clk), .rstN (rstN), .load (execLoad), .op (masterEx), .res (masterResult)
    );

    execUnit slaveExec (
        .clk (clk), .rstN (rstN), .load (execLoad), .op (slaveEx), .res (slaveResult)
    );

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import dualIssuePkg::*; (
    input  wire  clk,
    input  wire  rstN,
    input  wire  load,
    input  wire decodedOp op,
    output exResult res
);

    logic [31:0] opB;
    logic [31:0] aluOut;
    logic        rsEqRt;
    exResult     resNext;

    assign opB    = op.aluSelB ? op.immValue : op.rtValue;
    assign rsEqRt = (op.rsValue == op.rtValue);

    // --------------------------------------------------
    // alu
    // --------------------------------------------------
    always_comb begin
        case (op.aluOp)
            aluAdd:  aluOut = op.rsValue + opB;
            aluSub:  aluOut = op.rsValue - opB;
            aluAnd:  aluOut = op.rsValue & opB;
            aluOr:   aluOut = op.rsValue | opB;
            aluXor:  aluOut = op.rsValue ^ opB;
            aluSlt:  aluOut = {31'd0, $signed(op.rsValue) < $signed(opB)};
            aluSll:  aluOut = opB << op.shamt; // shifts rt.
            aluSrl:  aluOut = opB >> op.shamt;
            aluLui:  aluOut = {op.immValue[15:0], 16'h0000};
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        resNext              = '0;
        resNext.valid        = op.valid;
        resNext.regWen       = op.regWen;
        resNext.regWaddr     = op.regWaddr;
        resNext.result       = aluOut;
        resNext.memEn        = op.memEn;
        resNext.memWrite     = op.memWrite;
        resNext.storeData    = op.rtValue;
        resNext.branchTaken  = op.isBranch && rsEqRt;
        resNext.branchTarget = op.pc + 32'd4 + {op.immValue[29:0], 2'b00};
        resNext.reservedInst = op.reservedInst;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            res <= '0;
        end else if (load) begin
            res <= resNext;
        end
    end

endmodule

`default_nettype wire

// File: hdl/idExReg.sv
`timescale 1ns/1ps
`default_nettype none

module idExReg import dualIssuePkg::*; (
    input  wire  clk,
    input  wire  rstN,
    input  wire  clear,
    input  wire  load,
    input  wire decodedOp dIn,
    output decodedOp dOut
);

    // clear has priority over load.
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            dOut <= '0;
        end else if (load) begin
            dOut <= dIn;
        end
    end

endmodule

`default_nettype wire

// File: hdl/instDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instDecode import dualIssuePkg::*; (
    input  wire [31:0] inst,
    input  wire [31:0] pc,
    input  wire        instValid,
    input  wire operandPair operands,
    output decodedOp   op
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];

    always_comb begin
        op          = '0;
        op.valid    = instValid;
        op.pc       = pc;
        op.rsValue  = operands.rsValue;
        op.rtValue  = operands.rtValue;
        op.rsAddr   = inst[25:21];
        op.rtAddr   = inst[20:16];
        op.shamt    = inst[10:6];
        op.aluOp    = aluAdd;
        op.immValue = {{16{imm[15]}}, imm}; // sign extend by default.

        if (instValid) begin
            case (opcode)
                opSpecial: begin
                    op.regWen   = 1'b1;
                    op.regWaddr = inst[15:11];
                    op.usesRt   = 1'b1;
                    case (funct)
                        fnAddu:  op.aluOp = aluAdd;
                        fnSubu:  op.aluOp = aluSub;
                        fnAnd:   op.aluOp = aluAnd;
                        fnOr:    op.aluOp = aluOr;
                        fnXor:   op.aluOp = aluXor;
                        fnSlt:   op.aluOp = aluSlt;
                        fnSll:   op.aluOp = aluSll;
                        fnSrl:   op.aluOp = aluSrl;
                        default: begin
                            op.regWen       = 1'b0;
                            op.reservedInst = 1'b1;
                        end
                    endcase
                end
                opAddiu, opOri, opLui, opLw: begin
                    op.regWen   = 1'b1;
                    op.regWaddr = inst[20:16]; // i-type writes rt.
                    op.aluSelB  = 1'b1;
                    if (opcode == opOri) begin
                        op.aluOp    = aluOr;
                        op.immValue = {16'h0000, imm};
                    end else if (opcode == opLui) begin
                        op.aluOp    = aluLui;
                    end
                    op.memEn = (opcode == opLw);
                end
                opSw: begin
                    op.memEn    = 1'b1;
                    op.memWrite = 1'b1;
                    op.aluSelB  = 1'b1;
                    op.usesRt   = 1'b1; // store data.
                end
                opBeq: begin
                    op.isBranch = 1'b1;
                    op.usesRt   = 1'b1;
                    op.aluOp    = aluSub;
                end
                default: op.reservedInst = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/issueCheck.sv
`timescale 1ns/1ps
`default_nettype none

module issueCheck import dualIssuePkg::*; (
    input  wire decodedOp masterOp,
    input  wire decodedOp slaveOp,
    input  wire  stall,
    input  wire  flush,
    output logic slaveTaken,
    output logic masterLoad,
    output logic masterClear,
    output logic slaveLoad,
    output logic slaveClear,
    output logic execLoad
);

    logic masterWrites;
    logic rawHazard;
    logic slaveKind;
    logic canPair;

    // --------------------------------------------------
    // pairing rules
    // --------------------------------------------------
    assign masterWrites = masterOp.regWen && (masterOp.regWaddr != 5'd0);
    assign rawHazard    = masterWrites &&
                          ((masterOp.regWaddr == slaveOp.rsAddr) ||
                           (slaveOp.usesRt && (masterOp.regWaddr == slaveOp.rtAddr)));
    assign slaveKind    = !slaveOp.memEn && !slaveOp.isBranch && !slaveOp.reservedInst;
    assign canPair      = slaveOp.valid && slaveKind && !masterOp.isBranch && !rawHazard;

    // --------------------------------------------------
    // lane strobes
    // --------------------------------------------------
    assign slaveTaken  = canPair && !stall && !flush;
    assign masterLoad  = !stall;
    assign slaveLoad   = !stall;
    assign masterClear = flush;
    assign slaveClear  = flush || (!stall && !canPair); // refused slave becomes a bubble.
    assign execLoad    = !stall;

endmodule

`default_nettype wire
